//--- cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// major opcodes, instruction[30:25]
`define OP_TY_BASE 6'b100000
`define OP_ADDI    6'b101000
`define OP_ORI     6'b101100
`define OP_XORI    6'b101011
`define OP_MOVI    6'b100010
`define OP_LWI     6'b000010
`define OP_SWI     6'b001010
`define OP_TY_LS   6'b011100
`define OP_TY_B    6'b100110
`define OP_JJ      6'b100100

// base type sub-ops, instruction[4:0]
`define SUB_ADD   5'b00000
`define SUB_SUB   5'b00001
`define SUB_AND   5'b00010
`define SUB_XOR   5'b00011
`define SUB_OR    5'b00100
`define SUB_SLLI  5'b01000
`define SUB_SRLI  5'b01001
`define SUB_ROTRI 5'b01011

// load/store sub-ops, instruction[7:0]
`define SUB_LW 8'b00000010
`define SUB_SW 8'b00001010

// branch sub-op, instruction[14]
`define BR_BEQ 1'b0
`define BR_BNE 1'b1

`define REG_COUNT 32
`define RESET_PC  32'h0000_0000

`endif

//--- cpu_pkg.sv
`include "cpu_consts.svh"

package cpu_pkg;

	typedef enum logic [2:0] {
		FETCH,
		DECODE,
		EXECUTE,
		MEMACCESS,
		WRITEBACK
	} stage_e;

	typedef enum logic [5:0] {
		OPC_TY_BASE = `OP_TY_BASE,
		OPC_ADDI    = `OP_ADDI,
		OPC_ORI     = `OP_ORI,
		OPC_XORI    = `OP_XORI,
		OPC_MOVI    = `OP_MOVI,
		OPC_LWI     = `OP_LWI,
		OPC_SWI     = `OP_SWI,
		OPC_TY_LS   = `OP_TY_LS,
		OPC_TY_B    = `OP_TY_B,
		OPC_JJ      = `OP_JJ
	} opcode_e;

	typedef enum logic [1:0] {PC_4, PC_14BIT, PC_24BIT} pc_sel_e;

	typedef enum logic [2:0] {
		SRC2_RBDATA,
		SRC2_IMM,
		SRC2_LSWI,
		SRC2_LSW,
		SRC2_BENX,
		SRC2_NONE
	} alu_src2_e;

	typedef enum logic [2:0] {
		EXT_NONE,
		EXT_IMM5_ZE,
		EXT_IMM15_SE,
		EXT_IMM15_ZE,
		EXT_IMM20_SE
	} imm_ext_e;

	typedef enum logic [1:0] {WB_ALU, WB_IMM, WB_MEM} wb_sel_e;

	// sub_op holds the effective ALU operation, not only the raw base sub-op
	typedef struct packed {
		opcode_e    opcode;
		alu_src2_e  alu_src2;
		imm_ext_e   imm_ext;
		wb_sel_e    wb_sel;
		logic       dm_read;
		logic       dm_write;
		logic       reg_write;
		logic [4:0] sub_op;
		logic [1:0] sv;
		logic       branch_ne;
	} ctrl_t;

	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] instruction;
	} fetch_out_t;

	typedef struct packed {
		logic [31:0] pc;
		ctrl_t       ctrl;
		logic [31:0] ra_data;
		logic [31:0] rb_data;
		logic [31:0] rt_data;
		logic [31:0] imm;
		logic [4:0]  rt_addr;
		logic [13:0] imm14;
		logic [23:0] imm24;
	} decode_out_t;

	typedef struct packed {
		ctrl_t       ctrl;
		logic [31:0] result;
		logic [31:0] store_data;
		logic [4:0]  rt_addr;
		logic        zero;
		logic [31:0] branch_target;
		logic [31:0] jump_target;
	} exec_out_t;

	typedef struct packed {
		logic        reg_write;
		logic [4:0]  rt_addr;
		logic [31:0] data;
	} wb_t;

endpackage

//--- stage_controller.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module stage_controller (
	input  logic           clock,
	input  logic           reset,
	input  logic [31:0]    instruction,
	output logic           enable_fetch,
	output logic           enable_decode,
	output logic           enable_execute,
	output logic           enable_memaccess,
	output logic           enable_writeback,
	output cpu_pkg::ctrl_t ctrl
);
	import cpu_pkg::*;

	stage_e state;
	stage_e state_next;
	opcode_e opcode;
	logic [4:0] sub_op_base;
	logic [7:0] sub_op_ls;

	assign opcode = opcode_e'(instruction[30:25]);
	assign sub_op_base = instruction[4:0];
	assign sub_op_ls = instruction[7:0];

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			state <= FETCH;
		end else begin
			state <= state_next;
		end
	end

	always_comb begin
		case (state)
			FETCH:     state_next = DECODE;
			DECODE:    state_next = EXECUTE;
			EXECUTE:   state_next = MEMACCESS;
			MEMACCESS: state_next = WRITEBACK;
			default:   state_next = FETCH;
		endcase
	end

	// one stage active per cycle
	assign enable_fetch = (state == FETCH);
	assign enable_decode = (state == DECODE);
	assign enable_execute = (state == EXECUTE);
	assign enable_memaccess = (state == MEMACCESS);
	assign enable_writeback = (state == WRITEBACK);

	always_comb begin
		ctrl = '0;
		ctrl.opcode = opcode;
		ctrl.alu_src2 = SRC2_NONE;
		ctrl.imm_ext = EXT_NONE;
		ctrl.wb_sel = WB_ALU;
		ctrl.sub_op = `SUB_ADD;
		ctrl.sv = instruction[9:8];
		ctrl.branch_ne = (instruction[14] == `BR_BNE);
		case (opcode)
			OPC_TY_BASE: begin
				case (sub_op_base)
					`SUB_ADD, `SUB_SUB, `SUB_AND, `SUB_OR, `SUB_XOR: begin
						ctrl.alu_src2 = SRC2_RBDATA;
						ctrl.sub_op = sub_op_base;
						ctrl.reg_write = 1'b1;
					end
					`SUB_SRLI, `SUB_SLLI, `SUB_ROTRI: begin
						ctrl.alu_src2 = SRC2_IMM;
						ctrl.imm_ext = EXT_IMM5_ZE;
						ctrl.sub_op = sub_op_base;
						ctrl.reg_write = 1'b1;
					end
					default: ;
				endcase
			end
			OPC_ADDI: begin
				ctrl.alu_src2 = SRC2_IMM;
				ctrl.imm_ext = EXT_IMM15_SE;
				ctrl.reg_write = 1'b1;
			end
			OPC_ORI, OPC_XORI: begin
				ctrl.alu_src2 = SRC2_IMM;
				ctrl.imm_ext = EXT_IMM15_ZE;
				ctrl.sub_op = (opcode == OPC_ORI) ? `SUB_OR : `SUB_XOR;
				ctrl.reg_write = 1'b1;
			end
			OPC_MOVI: begin
				ctrl.imm_ext = EXT_IMM20_SE;
				ctrl.wb_sel = WB_IMM;
				ctrl.reg_write = 1'b1;
			end
			OPC_LWI, OPC_SWI: begin
				// word offset, scaled in execute
				ctrl.alu_src2 = SRC2_LSWI;
				ctrl.imm_ext = EXT_IMM15_ZE;
				ctrl.wb_sel = WB_MEM;
				ctrl.dm_read = (opcode == OPC_LWI);
				ctrl.dm_write = (opcode == OPC_SWI);
				ctrl.reg_write = (opcode == OPC_LWI);
			end
			OPC_TY_LS: begin
				if (sub_op_ls == `SUB_LW || sub_op_ls == `SUB_SW) begin
					ctrl.alu_src2 = SRC2_LSW;
					ctrl.wb_sel = WB_MEM;
					ctrl.dm_read = (sub_op_ls == `SUB_LW);
					ctrl.dm_write = (sub_op_ls == `SUB_SW);
					ctrl.reg_write = (sub_op_ls == `SUB_LW);
				end
			end
			OPC_TY_B: begin
				ctrl.alu_src2 = SRC2_BENX;
				ctrl.sub_op = `SUB_SUB;
			end
			default: ;
		endcase
	end

endmodule

//--- fetch_stage.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module fetch_stage (
	input  logic                clock,
	input  logic                reset,
	input  logic                enable_fetch,
	input  logic                enable_writeback,
	output logic [31:0]         imem_addr,
	input  logic [31:0]         imem_data,
	input  cpu_pkg::exec_out_t  exec,
	input  logic                branch_ne,
	input  cpu_pkg::opcode_e    opcode,
	output cpu_pkg::fetch_out_t fetched
);
	import cpu_pkg::*;

	logic [31:0] pc;
	logic [31:0] pc_next;
	logic branch_taken;
	pc_sel_e pc_select;

	assign imem_addr = pc;

	// zero flag comes from ra - rt
	assign branch_taken = branch_ne ? !exec.zero : exec.zero;

	always_comb begin
		case (opcode)
			OPC_TY_B: pc_select = branch_taken ? PC_14BIT : PC_4;
			OPC_JJ:   pc_select = PC_24BIT;
			default:  pc_select = PC_4;
		endcase
	end

	always_comb begin
		case (pc_select)
			PC_14BIT: pc_next = exec.branch_target;
			PC_24BIT: pc_next = exec.jump_target;
			default:  pc_next = pc + 32'd4;
		endcase
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			pc <= `RESET_PC;
			fetched <= '0;
		end else begin
			if (enable_fetch) begin
				fetched.pc <= pc;
				fetched.instruction <= imem_data;
			end
			if (enable_writeback) begin
				pc <= pc_next;
			end
		end
	end

endmodule

//--- decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 enable_decode,
	input  cpu_pkg::fetch_out_t  fetched,
	input  cpu_pkg::ctrl_t       ctrl,
	output logic [4:0]           ra_addr,
	output logic [4:0]           rb_addr,
	output logic [4:0]           rt_addr_rd,
	input  logic [31:0]          ra_data,
	input  logic [31:0]          rb_data,
	input  logic [31:0]          rt_data,
	output cpu_pkg::decode_out_t decoded
);
	import cpu_pkg::*;

	logic [31:0] instruction;
	logic [31:0] imm_ext;

	assign instruction = fetched.instruction;

	// register fields
	assign rt_addr_rd = instruction[24:20];
	assign ra_addr = instruction[19:15];
	assign rb_addr = instruction[14:10];

	always_comb begin
		case (ctrl.imm_ext)
			EXT_IMM5_ZE:  imm_ext = {27'd0, instruction[14:10]};
			EXT_IMM15_SE: imm_ext = {{17{instruction[14]}}, instruction[14:0]};
			EXT_IMM15_ZE: imm_ext = {17'd0, instruction[14:0]};
			EXT_IMM20_SE: imm_ext = {{12{instruction[19]}}, instruction[19:0]};
			default:      imm_ext = 32'd0;
		endcase
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			decoded <= '0;
		end else if (enable_decode) begin
			decoded.pc <= fetched.pc;
			decoded.ctrl <= ctrl;
			decoded.ra_data <= ra_data;
			decoded.rb_data <= rb_data;
			decoded.rt_data <= rt_data;
			decoded.imm <= imm_ext;
			decoded.rt_addr <= rt_addr_rd;
			decoded.imm14 <= instruction[13:0];
			decoded.imm24 <= instruction[23:0];
		end
	end

endmodule

//--- register_file.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module register_file (
	input  logic         clock,
	input  logic         reset,
	input  logic [4:0]   ra_addr,
	input  logic [4:0]   rb_addr,
	input  logic [4:0]   rt_addr_rd,
	output logic [31:0]  ra_data,
	output logic [31:0]  rb_data,
	output logic [31:0]  rt_data,
	input  cpu_pkg::wb_t wb,
	input  logic         enable_writeback
);
	logic [31:0] regs [`REG_COUNT];

	// asynchronous reads, r0 is writable
	assign ra_data = regs[ra_addr];
	assign rb_data = regs[rb_addr];
	assign rt_data = regs[rt_addr_rd];

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= 32'd0;
			end
		end else if (enable_writeback && wb.reg_write) begin
			regs[wb.rt_addr] <= wb.data;
		end
	end

endmodule

//--- execute_stage.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module execute_stage (
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 enable_execute,
	input  cpu_pkg::decode_out_t decoded,
	output cpu_pkg::exec_out_t   executed
);
	import cpu_pkg::*;

	ctrl_t ctrl;
	logic [31:0] operand1;
	logic [31:0] operand2;
	logic [31:0] result;
	logic [4:0] shamt;
	logic [63:0] rotated;
	logic [31:0] branch_target;
	logic [31:0] jump_target;

	assign ctrl = decoded.ctrl;
	assign operand1 = decoded.ra_data;

	always_comb begin
		case (ctrl.alu_src2)
			SRC2_RBDATA: operand2 = decoded.rb_data;
			SRC2_IMM:    operand2 = decoded.imm;
			SRC2_LSWI:   operand2 = {decoded.imm[29:0], 2'b00};
			SRC2_LSW:    operand2 = decoded.rb_data << ctrl.sv;
			SRC2_BENX:   operand2 = decoded.rt_data;
			default:     operand2 = 32'd0;
		endcase
	end

	assign shamt = operand2[4:0];
	assign rotated = {operand1, operand1} >> shamt;

	always_comb begin
		case (ctrl.sub_op)
			`SUB_SUB:   result = operand1 - operand2;
			`SUB_AND:   result = operand1 & operand2;
			`SUB_OR:    result = operand1 | operand2;
			`SUB_XOR:   result = operand1 ^ operand2;
			`SUB_SRLI:  result = operand1 >> shamt;
			`SUB_SLLI:  result = operand1 << shamt;
			`SUB_ROTRI: result = rotated[31:0];
			// add, also the address sum for loads and stores
			default:    result = operand1 + operand2;
		endcase
	end

	// halfword-scaled offsets
	assign branch_target = decoded.pc + {{17{decoded.imm14[13]}}, decoded.imm14, 1'b0};
	assign jump_target = decoded.pc + {{7{decoded.imm24[23]}}, decoded.imm24, 1'b0};

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			executed <= '0;
		end else if (enable_execute) begin
			executed.ctrl <= ctrl;
			executed.result <= result;
			executed.store_data <= decoded.rt_data;
			executed.rt_addr <= decoded.rt_addr;
			executed.zero <= (result == 32'd0);
			executed.branch_target <= branch_target;
			executed.jump_target <= jump_target;
		end
	end

endmodule

//--- memory_stage.sv
`timescale 1ns/1ps

module memory_stage (
	input  logic               clock,
	input  logic               reset,
	input  logic               enable_memaccess,
	input  cpu_pkg::exec_out_t executed,
	output logic [31:0]        dmem_addr,
	output logic [31:0]        dmem_wdata,
	output logic               dmem_read,
	output logic               dmem_write,
	input  logic [31:0]        dmem_rdata,
	input  logic [31:0]        imm_value,
	output cpu_pkg::wb_t       wb
);
	import cpu_pkg::*;

	logic [31:0] load_data;

	assign dmem_addr = executed.result;
	assign dmem_wdata = executed.store_data;

	// strobes only in the memaccess cycle
	assign dmem_read = enable_memaccess & executed.ctrl.dm_read;
	assign dmem_write = enable_memaccess & executed.ctrl.dm_write;

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			load_data <= 32'd0;
		end else if (dmem_read) begin
			load_data <= dmem_rdata;
		end
	end

	always_comb begin
		wb.reg_write = executed.ctrl.reg_write;
		wb.rt_addr = executed.rt_addr;
		case (executed.ctrl.wb_sel)
			WB_MEM:  wb.data = load_data;
			WB_IMM:  wb.data = imm_value;
			default: wb.data = executed.result;
		endcase
	end

endmodule

//--- nds_core.sv
`timescale 1ns/1ps

module nds_core (
	input  logic        clock,
	input  logic        reset,
	output logic [31:0] imem_addr,
	input  logic [31:0] imem_data,
	output logic [31:0] dmem_addr,
	output logic [31:0] dmem_wdata,
	output logic        dmem_read,
	output logic        dmem_write,
	input  logic [31:0] dmem_rdata
);
	import cpu_pkg::*;

	logic enable_fetch;
	logic enable_decode;
	logic enable_execute;
	logic enable_memaccess;
	logic enable_writeback;

	ctrl_t ctrl;
	fetch_out_t fetched;
	decode_out_t decoded;
	exec_out_t executed;
	wb_t wb;

	logic [4:0] ra_addr;
	logic [4:0] rb_addr;
	logic [4:0] rt_addr_rd;
	logic [31:0] ra_data;
	logic [31:0] rb_data;
	logic [31:0] rt_data;

	stage_controller stage_controller_i (
		.clock            (clock),
		.reset            (reset),
		.instruction      (fetched.instruction),
		.enable_fetch     (enable_fetch),
		.enable_decode    (enable_decode),
		.enable_execute   (enable_execute),
		.enable_memaccess (enable_memaccess),
		.enable_writeback (enable_writeback),
		.ctrl             (ctrl)
	);

	fetch_stage fetch_stage_i (
		.clock            (clock),
		.reset            (reset),
		.enable_fetch     (enable_fetch),
		.enable_writeback (enable_writeback),
		.imem_addr        (imem_addr),
		.imem_data        (imem_data),
		.exec             (executed),
		.branch_ne        (ctrl.branch_ne),
		.opcode           (ctrl.opcode),
		.fetched          (fetched)
	);

	decode_stage decode_stage_i (
		.clock         (clock),
		.reset         (reset),
		.enable_decode (enable_decode),
		.fetched       (fetched),
		.ctrl          (ctrl),
		.ra_addr       (ra_addr),
		.rb_addr       (rb_addr),
		.rt_addr_rd    (rt_addr_rd),
		.ra_data       (ra_data),
		.rb_data       (rb_data),
		.rt_data       (rt_data),
		.decoded       (decoded)
	);

	register_file register_file_i (
		.clock            (clock),
		.reset            (reset),
		.ra_addr          (ra_addr),
		.rb_addr          (rb_addr),
		.rt_addr_rd       (rt_addr_rd),
		.ra_data          (ra_data),
		.rb_data          (rb_data),
		.rt_data          (rt_data),
		.wb               (wb),
		.enable_writeback (enable_writeback)
	);

	execute_stage execute_stage_i (
		.clock          (clock),
		.reset          (reset),
		.enable_execute (enable_execute),
		.decoded        (decoded),
		.executed       (executed)
	);

	memory_stage memory_stage_i (
		.clock            (clock),
		.reset            (reset),
		.enable_memaccess (enable_memaccess),
		.executed         (executed),
		.dmem_addr        (dmem_addr),
		.dmem_wdata       (dmem_wdata),
		.dmem_read        (dmem_read),
		.dmem_write       (dmem_write),
		.dmem_rdata       (dmem_rdata),
		.imm_value        (decoded.imm),
		.wb               (wb)
	);

endmodule

//--- tb_program.svh
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

`include "cpu_consts.svh"

// word-indexed memory models
logic [31:0] imem [64];
logic [31:0] dmem [256];
int prog_len;

logic [31:0] lcg_state = 32'h02ab_4a63;

function automatic logic [31:0] next_random();
	lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
	return lcg_state;
endfunction

function automatic logic [31:0] base_insn(input logic [4:0] sub, input logic [4:0] rt,
		input logic [4:0] ra, input logic [4:0] rb);
	return {1'b0, `OP_TY_BASE, rt, ra, rb, 5'd0, sub};
endfunction

function automatic logic [31:0] imm15_insn(input logic [5:0] op, input logic [4:0] rt,
		input logic [4:0] ra, input logic [14:0] imm15);
	return {1'b0, op, rt, ra, imm15};
endfunction

function automatic logic [31:0] movi_insn(input logic [4:0] rt, input logic [19:0] imm20);
	return {1'b0, `OP_MOVI, rt, imm20};
endfunction

// rb shifted by sv
function automatic logic [31:0] ls_insn(input logic [7:0] sub, input logic [4:0] rt,
		input logic [4:0] ra, input logic [4:0] rb, input logic [1:0] sv);
	return {1'b0, `OP_TY_LS, rt, ra, rb, sv, sub};
endfunction

function automatic logic [31:0] branch_insn(input logic ne, input logic [4:0] rt,
		input logic [4:0] ra, input logic [13:0] imm14);
	return {1'b0, `OP_TY_B, rt, ra, ne, imm14};
endfunction

function automatic logic [31:0] jump_insn(input logic [23:0] imm24);
	return {1'b0, `OP_JJ, 1'b0, imm24};
endfunction

task automatic place(input logic [31:0] word);
	imem[prog_len[5:0]] = word;
	prog_len++;
endtask

`endif

//--- tb_nds_core.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module tb_nds_core;

	localparam int fetch_len = 6;
	localparam int alu_len = 14;
	localparam int imm_len = 13;
	localparam int ls_len = 20;
	localparam int branch_len = 9;
	localparam int jump_len = 6;
	localparam int watchdog_cycles = (fetch_len + alu_len + imm_len + ls_len + branch_len
		+ jump_len) * 5 + 6 * 20;

	logic clock = 1'b0;
	logic reset;
	logic [31:0] imem_addr;
	logic [31:0] imem_data;
	logic [31:0] dmem_addr;
	logic [31:0] dmem_wdata;
	logic dmem_read;
	logic dmem_write;
	logic [31:0] dmem_rdata;

	logic [31:0] fetch_log [$];
	logic [31:0] cycle_addr_log [$];
	logic [31:0] store_addr_log [$];
	logic [31:0] store_data_log [$];
	logic [31:0] exp_fetch [$];
	logic [31:0] exp_store_addr [$];
	logic [31:0] exp_store_data [$];

	`include "tb_program.svh"

	nds_core nds_core_i (
		.clock      (clock),
		.reset      (reset),
		.imem_addr  (imem_addr),
		.imem_data  (imem_data),
		.dmem_addr  (dmem_addr),
		.dmem_wdata (dmem_wdata),
		.dmem_read  (dmem_read),
		.dmem_write (dmem_write),
		.dmem_rdata (dmem_rdata)
	);

	always #5 clock = ~clock;

	// memories answer within the cycle
	always @(posedge clock) begin
		#1;
		imem_data = imem[imem_addr[7:2]];
		dmem_rdata = dmem_read ? dmem[dmem_addr[9:2]] : 32'd0;
	end

	always @(negedge clock) begin
		if (dmem_write) begin
			dmem[dmem_addr[9:2]] = dmem_wdata;
			store_addr_log.push_back(dmem_addr);
			store_data_log.push_back(dmem_wdata);
		end
	end

	task automatic check(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			$display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
			$display("TESTS FAILED");
			$fatal(1, "stopping at the first mismatch");
		end
	endtask

	function automatic logic [31:0] sext20(input logic [19:0] imm20);
		return {{12{imm20[19]}}, imm20};
	endfunction

	function automatic logic [31:0] branch_dest(input logic [31:0] pc, input logic [13:0] imm14);
		return pc + ({{18{imm14[13]}}, imm14} << 1);
	endfunction

	function automatic logic [31:0] jump_dest(input logic [31:0] pc, input logic [23:0] imm24);
		return pc + ({{8{imm24[23]}}, imm24} << 1);
	endfunction

	task automatic expect_store(input logic [31:0] addr, input logic [31:0] data);
		exp_store_addr.push_back(addr);
		exp_store_data.push_back(data);
	endtask

	// SWI rt into a word slot based on r0
	task automatic store_result(input logic [4:0] rt, input logic [14:0] slot,
			input logic [31:0] value);
		place(imm15_insn(`OP_SWI, rt, 5'd0, slot));
		expect_store({15'd0, slot, 2'b00}, value);
	endtask

	task automatic prepare_test();
		int i;
		fetch_log.delete();
		cycle_addr_log.delete();
		store_addr_log.delete();
		store_data_log.delete();
		exp_fetch.delete();
		exp_store_addr.delete();
		exp_store_data.delete();
		prog_len = 0;
		// undecoded opcode 6'b111111 everywhere past the program
		for (i = 0; i < 64; i++) begin
			imem[i] = {1'b0, 6'b111111, 25'(i)};
		end
		for (i = 0; i < 256; i++) begin
			dmem[i] = 32'hc3c3_0000 ^ (32'(i) * 32'h0001_0101);
		end
	endtask

	task automatic apply_reset(input string name);
		@(posedge clock);
		#1;
		reset = 1'b1;
		repeat (4) begin
			@(negedge clock);
			check({name, " reset imem_addr"}, `RESET_PC, imem_addr);
			check({name, " reset strobes"}, 32'd0, {30'd0, dmem_read, dmem_write});
			@(posedge clock);
		end
		#1;
		reset = 1'b0;
	endtask

	// instruction n fetched in cycle 5n
	task automatic run_core(input string name, input int insn_count);
		int cycle;
		apply_reset(name);
		for (cycle = 0; cycle < insn_count * 5; cycle++) begin
			@(negedge clock);
			if (cycle % 5 == 0) begin
				fetch_log.push_back(imem_addr);
			end
			if (cycle % 5 != 3) begin
				check({name, " idle strobes"}, 32'd0, {30'd0, dmem_read, dmem_write});
			end
			cycle_addr_log.push_back(imem_addr);
		end
		@(posedge clock);
	endtask

	task automatic compare_traces(input string name);
		foreach (exp_fetch[n]) begin
			check({name, " fetch address"}, exp_fetch[n], fetch_log[n]);
		end
		check({name, " store count"}, 32'(exp_store_addr.size()),
			32'(store_addr_log.size()));
		foreach (exp_store_addr[n]) begin
			check({name, " store address"}, exp_store_addr[n], store_addr_log[n]);
			check({name, " store data"}, exp_store_data[n], store_data_log[n]);
		end
	endtask

	task automatic test_fetch_sequence();
		logic [31:0] r;
		int n;
		prepare_test();
		r = next_random();
		place(movi_insn(5'd1, r[19:0]));
		place(movi_insn(5'd2, r[31:12]));
		place(base_insn(`SUB_ADD, 5'd3, 5'd1, 5'd2));
		place(base_insn(`SUB_SUB, 5'd4, 5'd1, 5'd2));
		place(imm15_insn(`OP_ORI, 5'd5, 5'd1, r[14:0]));
		place(base_insn(`SUB_XOR, 5'd6, 5'd1, 5'd2));
		for (n = 0; n < fetch_len; n++) begin
			exp_fetch.push_back(32'(4 * n));
		end
		run_core("fetch_sequence", fetch_len);
		foreach (cycle_addr_log[c]) begin
			check("fetch_sequence imem_addr", 32'(4 * (c / 5)), cycle_addr_log[c]);
		end
		compare_traces("fetch_sequence");
	endtask

	task automatic test_register_alu();
		logic [31:0] r;
		logic [19:0] a20;
		logic [19:0] b20;
		logic [31:0] a;
		logic [31:0] b;
		int n;
		prepare_test();
		r = next_random();
		// a negative and b positive after sign extension
		a20 = r[19:0] | 20'h80000;
		r = next_random();
		b20 = r[19:0] & 20'h7ffff;
		a = sext20(a20);
		b = sext20(b20);
		place(movi_insn(5'd1, a20));
		place(movi_insn(5'd2, b20));
		store_result(5'd1, 15'd0, a);
		store_result(5'd2, 15'd1, b);
		place(base_insn(`SUB_ADD, 5'd3, 5'd1, 5'd2));
		store_result(5'd3, 15'd2, a + b);
		place(base_insn(`SUB_SUB, 5'd4, 5'd1, 5'd2));
		store_result(5'd4, 15'd3, a - b);
		place(base_insn(`SUB_AND, 5'd5, 5'd1, 5'd2));
		store_result(5'd5, 15'd4, a & b);
		place(base_insn(`SUB_OR, 5'd6, 5'd1, 5'd2));
		store_result(5'd6, 15'd5, a | b);
		place(base_insn(`SUB_XOR, 5'd7, 5'd1, 5'd2));
		store_result(5'd7, 15'd6, a ^ b);
		for (n = 0; n < alu_len; n++) begin
			exp_fetch.push_back(32'(4 * n));
		end
		run_core("register_alu", alu_len);
		compare_traces("register_alu");
	endtask

	task automatic test_immediate_ops();
		logic [31:0] r;
		logic [19:0] x20;
		logic [31:0] x;
		logic [14:0] imm_a;
		logic [14:0] imm_o;
		logic [14:0] imm_x;
		logic [4:0] s1;
		logic [4:0] s2;
		logic [4:0] s3;
		int n;
		prepare_test();
		r = next_random();
		x20 = r[19:0] | 20'h80000;
		x = sext20(x20);
		// bit 14 set shows sign versus zero extension
		imm_a = r[14:0] | 15'h4000;
		r = next_random();
		imm_o = r[14:0] | 15'h4000;
		imm_x = r[29:15] | 15'h4000;
		r = next_random();
		s1 = 5'(r % 32'd31) + 5'd1;
		s2 = 5'((r >> 8) % 32'd31) + 5'd1;
		s3 = 5'((r >> 16) % 32'd31) + 5'd1;
		place(movi_insn(5'd1, x20));
		place(imm15_insn(`OP_ADDI, 5'd2, 5'd1, imm_a));
		store_result(5'd2, 15'd0, x + {{17{imm_a[14]}}, imm_a});
		place(imm15_insn(`OP_ORI, 5'd3, 5'd0, imm_o));
		store_result(5'd3, 15'd1, {17'd0, imm_o});
		place(imm15_insn(`OP_XORI, 5'd4, 5'd1, imm_x));
		store_result(5'd4, 15'd2, x ^ {17'd0, imm_x});
		place(base_insn(`SUB_SRLI, 5'd5, 5'd1, s1));
		store_result(5'd5, 15'd3, x >> s1);
		place(base_insn(`SUB_SLLI, 5'd6, 5'd1, s2));
		store_result(5'd6, 15'd4, x << s2);
		place(base_insn(`SUB_ROTRI, 5'd7, 5'd1, s3));
		store_result(5'd7, 15'd5, (x >> s3) | (x << (32 - s3)));
		for (n = 0; n < imm_len; n++) begin
			exp_fetch.push_back(32'(4 * n));
		end
		run_core("immediate_ops", imm_len);
		compare_traces("immediate_ops");
	endtask

	task automatic test_load_store();
		logic [31:0] r;
		logic [14:0] k;
		logic [31:0] load_idx;
		logic [31:0] store_idx;
		logic [31:0] load_addr;
		int i;
		int s;
		prepare_test();
		// loads from 0x100..0x1ff and stores from 0x200 up
		for (i = 64; i < 128; i++) begin
			dmem[i] = next_random();
		end
		r = next_random();
		k = {11'd0, r[3:0]};
		load_addr = 32'h100 + {15'd0, k, 2'b00};
		place(movi_insn(5'd1, 20'h00100));
		place(movi_insn(5'd2, 20'h00200));
		place(imm15_insn(`OP_LWI, 5'd3, 5'd1, k));
		place(ls_insn(`SUB_SW, 5'd3, 5'd2, 5'd0, 2'd0));
		expect_store(32'h200, dmem[load_addr[9:2]]);
		for (s = 0; s < 4; s++) begin
			r = next_random();
			load_idx = {27'd0, r[2:0], 2'b00};
			store_idx = {27'd0, r[10:8], 2'b00};
			load_addr = 32'h100 + (load_idx << s);
			place(movi_insn(5'd5, load_idx[19:0]));
			place(ls_insn(`SUB_LW, 5'd6, 5'd1, 5'd5, 2'(s)));
			place(movi_insn(5'd7, store_idx[19:0]));
			place(ls_insn(`SUB_SW, 5'd6, 5'd2, 5'd7, 2'(s)));
			expect_store(32'h200 + (store_idx << s), dmem[load_addr[9:2]]);
		end
		for (i = 0; i < ls_len; i++) begin
			exp_fetch.push_back(32'(4 * i));
		end
		run_core("load_store", ls_len);
		compare_traces("load_store");
	endtask

	task automatic test_branches();
		logic [31:0] r;
		logic [19:0] v20;
		logic [19:0] w20;
		int n;
		prepare_test();
		r = next_random();
		v20 = r[19:0];
		w20 = ~r[19:0];
		place(movi_insn(5'd1, v20));
		place(movi_insn(5'd2, v20));
		place(movi_insn(5'd3, w20));
		place(branch_insn(`BR_BEQ, 5'd2, 5'd1, 14'd4));
		place(imm15_insn(`OP_SWI, 5'd1, 5'd0, 15'h10));
		place(branch_insn(`BR_BEQ, 5'd3, 5'd1, 14'd4));
		place(imm15_insn(`OP_SWI, 5'd1, 5'd0, 15'h11));
		place(branch_insn(`BR_BNE, 5'd3, 5'd1, 14'd4));
		place(imm15_insn(`OP_SWI, 5'd2, 5'd0, 15'h12));
		place(branch_insn(`BR_BNE, 5'd2, 5'd1, 14'd4));
		place(imm15_insn(`OP_SWI, 5'd3, 5'd0, 15'h13));
		for (n = 0; n < 4; n++) begin
			exp_fetch.push_back(32'(4 * n));
		end
		// beq taken, beq not taken, bne taken, bne not taken
		exp_fetch.push_back(branch_dest(32'd12, 14'd4));
		exp_fetch.push_back(exp_fetch[4] + 32'd4);
		exp_fetch.push_back(exp_fetch[5] + 32'd4);
		exp_fetch.push_back(branch_dest(exp_fetch[6], 14'd4));
		exp_fetch.push_back(exp_fetch[7] + 32'd4);
		expect_store(32'h44, sext20(v20));
		expect_store(32'h4c, sext20(w20));
		run_core("branches", branch_len);
		compare_traces("branches");
	endtask

	task automatic test_jumps();
		logic [31:0] r;
		logic [31:0] v;
		prepare_test();
		r = next_random();
		v = sext20(r[19:0]);
		place(movi_insn(5'd1, r[19:0]));
		place(jump_insn(24'd8));
		place(imm15_insn(`OP_SWI, 5'd1, 5'd0, 15'h20));
		place(imm15_insn(`OP_SWI, 5'd1, 5'd0, 15'h21));
		place(jump_insn(24'd6));
		place(jump_insn(-24'sd4));
		place(imm15_insn(`OP_SWI, 5'd1, 5'd0, 15'h22));
		place(imm15_insn(`OP_SWI, 5'd1, 5'd0, 15'h23));
		exp_fetch.push_back(32'd0);
		exp_fetch.push_back(32'd4);
		exp_fetch.push_back(jump_dest(32'd4, 24'd8));
		exp_fetch.push_back(jump_dest(exp_fetch[2], -24'sd4));
		exp_fetch.push_back(exp_fetch[3] + 32'd4);
		exp_fetch.push_back(jump_dest(exp_fetch[4], 24'd6));
		expect_store(32'h84, v);
		expect_store(32'h8c, v);
		run_core("jumps", jump_len);
		compare_traces("jumps");
	endtask

	initial begin
		reset = 1'b1;
		imem_data = 32'd0;
		dmem_rdata = 32'd0;
		test_fetch_sequence();
		test_register_alu();
		test_immediate_ops();
		test_load_store();
		test_branches();
		test_jumps();
		$display("TESTS PASSED");
		$finish;
	end

	initial begin
		#(watchdog_cycles * 10);
		$display("timeout after %0d cycles, the tests did not finish", watchdog_cycles);
		$display("TESTS FAILED");
		$fatal(1, "watchdog expired");
	end

endmodule

//--- nds_core.f
+incdir+.
cpu_pkg.sv
stage_controller.sv
fetch_stage.sv
decode_stage.sv
register_file.sv
execute_stage.sv
memory_stage.sv
nds_core.sv
tb_nds_core.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary -j 0 --top-module tb_nds_core -f nds_core.f
./obj_dir/Vtb_nds_core
